// File: organ_settings.svh
`ifndef ORGAN_SETTINGS_SVH
`define ORGAN_SETTINGS_SVH

// ==========================================================================
// Note half-periods in 50 MHz cycles, 50e6 / (2 * f)
// ==========================================================================
`define ORGAN_DIV_DO  47801   // 523 Hz
`define ORGAN_DIV_RE  42589   // 587 Hz
`define ORGAN_DIV_MI  37936   // 659 Hz
`define ORGAN_DIV_FA  35817   // 698 Hz
`define ORGAN_DIV_SO  31928   // 783 Hz
`define ORGAN_DIV_LA  28409   // 880 Hz
`define ORGAN_DIV_SI  25329   // 987 Hz
`define ORGAN_DIV_DO2 23900   // 1046 Hz

// ==========================================================================
// Speed and sampling count
// ==========================================================================
`define ORGAN_SPEED_STEP           100
`define ORGAN_SAMPLE_COUNT_DEFAULT 12499   // 2 kHz sampling

// Tick periods
`define ORGAN_LED_TICK_CYCLES 25000000   // One LED step per half second
`define ORGAN_REPEAT_CYCLES   5000000    // 10 repeats per second
`define ORGAN_REFRESH_CYCLES  25000000   // 2 Hz display refresh

// Pad character for note names
`define ORGAN_CHAR_SPACE 8'h20

`endif

// File: organ_pkg.sv
`default_nettype none

package organ_pkg;

  // ==========================================================================
  // Tone path
  // ==========================================================================

  // Switch code, 0 is Do and 7 is high Do
  typedef logic [2:0] note_sel_t;

  // Half-period count of the tone divider
  typedef logic [15:0] tone_div_t;

  typedef logic signed [7:0] sample_t;   // Signed audio sample

  // Four ASCII characters, first one in the top byte
  typedef logic [31:0] note_name_t;

  // ==========================================================================
  // Speed and display path
  // ==========================================================================

  typedef logic signed [15:0] speed_t;   // Signed speed offset

  typedef logic [15:0] sample_count_t;   // Default count plus speed

  typedef logic [3:0] hex_digit_t;

  // Active low, bit 0 is segment a
  typedef logic [6:0] seg_t;

  // LED bank
  typedef logic [7:0] led_t;

endpackage

`default_nettype wire

// File: tone_generator.sv
`timescale 1ns/1ns
`default_nettype none
`include "organ_settings.svh"

module tone_generator (
  input  wire                        CLK_50M,
  input  wire                        rst,
  input  wire organ_pkg::note_sel_t  note_sel,
  input  wire                        sound_en,
  output organ_pkg::sample_t         audio_sample,
  output organ_pkg::note_name_t      note_name
);

  organ_pkg::note_sel_t note_q;        // Registered note code
  organ_pkg::tone_div_t half_period;
  organ_pkg::tone_div_t div_cnt;
  logic                 wave;
  logic                 gated_wave;

  // Divisor table, looked up from the registered code
  always_comb begin
    case (note_q)
      3'd0:    half_period = organ_pkg::tone_div_t'(`ORGAN_DIV_DO);
      3'd1:    half_period = organ_pkg::tone_div_t'(`ORGAN_DIV_RE);
      3'd2:    half_period = organ_pkg::tone_div_t'(`ORGAN_DIV_MI);
      3'd3:    half_period = organ_pkg::tone_div_t'(`ORGAN_DIV_FA);
      3'd4:    half_period = organ_pkg::tone_div_t'(`ORGAN_DIV_SO);
      3'd5:    half_period = organ_pkg::tone_div_t'(`ORGAN_DIV_LA);
      3'd6:    half_period = organ_pkg::tone_div_t'(`ORGAN_DIV_SI);
      default: half_period = organ_pkg::tone_div_t'(`ORGAN_DIV_DO2);
    endcase
  end

  // Name follows the switches directly
  always_comb begin
    case (note_sel)
      3'd0:    note_name = {"Do", `ORGAN_CHAR_SPACE, `ORGAN_CHAR_SPACE};
      3'd1:    note_name = {"Re", `ORGAN_CHAR_SPACE, `ORGAN_CHAR_SPACE};
      3'd2:    note_name = {"Mi", `ORGAN_CHAR_SPACE, `ORGAN_CHAR_SPACE};
      3'd3:    note_name = {"Fa", `ORGAN_CHAR_SPACE, `ORGAN_CHAR_SPACE};
      3'd4:    note_name = {"So", `ORGAN_CHAR_SPACE, `ORGAN_CHAR_SPACE};
      3'd5:    note_name = {"La", `ORGAN_CHAR_SPACE, `ORGAN_CHAR_SPACE};
      3'd6:    note_name = {"Si", `ORGAN_CHAR_SPACE, `ORGAN_CHAR_SPACE};
      default: note_name = {"Do2", `ORGAN_CHAR_SPACE};
    endcase
  end

  // ==========================================================================
  // Tone divider and square wave
  // ==========================================================================
  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      note_q  <= '0;
      div_cnt <= '0;
      wave    <= 1'b0;
    end else if (note_sel != note_q) begin
      note_q  <= note_sel;   // New note restarts the period
      div_cnt <= '0;
    end else if (div_cnt == half_period - 16'd1) begin
      div_cnt <= '0;
      wave    <= ~wave;      // Half period done
    end else begin
      div_cnt <= div_cnt + 16'd1;
    end
  end

  assign gated_wave = wave & sound_en;

  // High gives 127, low gives -128
  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      audio_sample <= 8'sh80;
    end else begin
      audio_sample <= {~gated_wave, {7{gated_wave}}};
    end
  end

endmodule

`default_nettype wire

// File: led_chaser.sv
`timescale 1ns/1ns
`default_nettype none
`include "organ_settings.svh"

module led_chaser #(
  parameter int TICK_CYCLES = `ORGAN_LED_TICK_CYCLES
) (
  input  wire              CLK_50M,
  input  wire              rst,
  output organ_pkg::led_t  led
);

  localparam int CNT_W = $clog2(TICK_CYCLES + 1);

  logic [CNT_W-1:0] tick_cnt;
  logic             tick;

  // ==========================================================================
  // Step tick
  // ==========================================================================
  assign tick = (tick_cnt == CNT_W'(TICK_CYCLES - 1));

  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // Walking LED, bit 7 wraps back to bit 0
  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      led <= 8'b0000_0001;
    end else if (tick) begin
      led <= {led[6:0], led[7]};
    end
  end

endmodule

`default_nettype wire

// File: speed_control.sv
`timescale 1ns/1ns
`default_nettype none
`include "organ_settings.svh"

module speed_control #(
  parameter int REPEAT_CYCLES = `ORGAN_REPEAT_CYCLES
) (
  input  wire                       CLK_50M,
  input  wire                       rst,
  input  wire                       key_up_n,
  input  wire                       key_down_n,
  input  wire                       key_reset_n,
  output organ_pkg::sample_count_t  sample_count
);

  localparam int WIN_W = $clog2(REPEAT_CYCLES + 1);

  localparam organ_pkg::speed_t SPEED_STEP = organ_pkg::speed_t'(`ORGAN_SPEED_STEP);

  localparam organ_pkg::sample_count_t COUNT_DEFAULT =
    organ_pkg::sample_count_t'(`ORGAN_SAMPLE_COUNT_DEFAULT);

  logic [2:0]       key_meta;   // {reset, down, up}, active high
  logic [2:0]       key_sync;
  logic             up_held;
  logic             down_held;
  logic             clr_held;

  logic [WIN_W-1:0] win_cnt;
  logic             win_end;

  organ_pkg::speed_t speed;

  // ==========================================================================
  // Key synchronizers
  // ==========================================================================
  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      key_meta <= '0;
      key_sync <= '0;
    end else begin
      key_meta <= {~key_reset_n, ~key_down_n, ~key_up_n};   // Keys are active low
      key_sync <= key_meta;
    end
  end

  assign up_held   = key_sync[0];
  assign down_held = key_sync[1];
  assign clr_held  = key_sync[2];

  // Free-running repeat window
  assign win_end = (win_cnt == WIN_W'(REPEAT_CYCLES - 1));

  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      win_cnt <= '0;
    end else if (win_end) begin
      win_cnt <= '0;
    end else begin
      win_cnt <= win_cnt + 1'b1;
    end
  end

  // ==========================================================================
  // Speed register
  // ==========================================================================
  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      speed <= '0;
    end else if (clr_held) begin
      speed <= '0;                    // Clear wins over up and down
    end else if (win_end) begin
      if (up_held && !down_held) begin
        speed <= speed + SPEED_STEP;
      end else if (down_held && !up_held) begin
        speed <= speed - SPEED_STEP;
      end
    end
  end

  // Sampling count, wraps modulo 2^16
  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      sample_count <= COUNT_DEFAULT;
    end else begin
      sample_count <= COUNT_DEFAULT + organ_pkg::sample_count_t'(speed);
    end
  end

endmodule

`default_nettype wire

// File: hex_display.sv
`timescale 1ns/1ns
`default_nettype none
`include "organ_settings.svh"

module hex_display #(
  parameter int REFRESH_CYCLES = `ORGAN_REFRESH_CYCLES
) (
  input  wire                            CLK_50M,
  input  wire                            rst,
  input  wire organ_pkg::sample_count_t  sample_count,
  output organ_pkg::seg_t                hex0,
  output organ_pkg::seg_t                hex1,
  output organ_pkg::seg_t                hex2,
  output organ_pkg::seg_t                hex3,
  output organ_pkg::seg_t                hex4,
  output organ_pkg::seg_t                hex5
);

  localparam int REF_W = $clog2(REFRESH_CYCLES + 1);

  logic [REF_W-1:0] ref_cnt;
  logic             refresh;
  logic [23:0]      disp_q;      // Six digits on show

  // Hex digit to active-low segments
  function automatic organ_pkg::seg_t seg_decode(input organ_pkg::hex_digit_t d);
    case (d)
      4'h0: seg_decode = 7'h40;
      4'h1: seg_decode = 7'h79;
      4'h2: seg_decode = 7'h24;
      4'h3: seg_decode = 7'h30;
      4'h4: seg_decode = 7'h19;
      4'h5: seg_decode = 7'h12;
      4'h6: seg_decode = 7'h02;
      4'h7: seg_decode = 7'h78;
      4'h8: seg_decode = 7'h00;
      4'h9: seg_decode = 7'h10;
      4'hA: seg_decode = 7'h08;
      4'hB: seg_decode = 7'h03;
      4'hC: seg_decode = 7'h46;
      4'hD: seg_decode = 7'h21;
      4'hE: seg_decode = 7'h06;
      default: seg_decode = 7'h0E;
    endcase
  endfunction

  assign refresh = (ref_cnt == REF_W'(REFRESH_CYCLES - 1));

  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      ref_cnt <= '0;
      disp_q  <= 24'(`ORGAN_SAMPLE_COUNT_DEFAULT);
    end else if (refresh) begin
      ref_cnt <= '0;
      disp_q  <= {8'h00, sample_count};   // Zero-extended to six digits
    end else begin
      ref_cnt <= ref_cnt + 1'b1;
    end
  end

  assign hex0 = seg_decode(disp_q[3:0]);   // Lowest digit
  assign hex1 = seg_decode(disp_q[7:4]);
  assign hex2 = seg_decode(disp_q[11:8]);
  assign hex3 = seg_decode(disp_q[15:12]);
  assign hex4 = seg_decode(disp_q[19:16]);
  assign hex5 = seg_decode(disp_q[23:20]);

endmodule

`default_nettype wire

// File: organ_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "organ_settings.svh"

module organ_top #(
  parameter int LED_TICK_CYCLES = `ORGAN_LED_TICK_CYCLES,
  parameter int REPEAT_CYCLES   = `ORGAN_REPEAT_CYCLES,
  parameter int REFRESH_CYCLES  = `ORGAN_REFRESH_CYCLES
) (
  input  wire                        CLK_50M,
  input  wire                        rst,
  input  wire organ_pkg::note_sel_t  note_sel,
  input  wire                        sound_en,
  input  wire                        key_up_n,
  input  wire                        key_down_n,
  input  wire                        key_reset_n,
  output organ_pkg::led_t            led,
  output organ_pkg::sample_t         audio_sample,
  output organ_pkg::note_name_t      note_name,
  output organ_pkg::seg_t            hex0,
  output organ_pkg::seg_t            hex1,
  output organ_pkg::seg_t            hex2,
  output organ_pkg::seg_t            hex3,
  output organ_pkg::seg_t            hex4,
  output organ_pkg::seg_t            hex5
);

  organ_pkg::sample_count_t sample_count;   // Speed path to the display

  // ==========================================================================
  // Tone and LEDs
  // ==========================================================================
  tone_generator i_tone_generator (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .note_sel     (note_sel),
    .sound_en     (sound_en),
    .audio_sample (audio_sample),
    .note_name    (note_name)
  );

  led_chaser #(.TICK_CYCLES(LED_TICK_CYCLES)) i_led_chaser (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .led     (led)
  );

  // ==========================================================================
  // Speed keys and count display
  // ==========================================================================
  speed_control #(.REPEAT_CYCLES(REPEAT_CYCLES)) i_speed_control (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .key_up_n     (key_up_n),
    .key_down_n   (key_down_n),
    .key_reset_n  (key_reset_n),
    .sample_count (sample_count)
  );

  hex_display #(.REFRESH_CYCLES(REFRESH_CYCLES)) i_hex_display (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .sample_count (sample_count),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

endmodule

`default_nettype wire

// File: tb_organ_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_organ_top;

  localparam int LED_TICK   = 50;
  localparam int REPEAT     = 40;
  localparam int REFRESH    = 30;
  localparam int COUNT_BASE = 12499;
  localparam int STEP       = 100;

  // Half periods and names per switch code
  localparam int DIV_REF [8] = '{47801, 42589, 37936, 35817, 31928, 28409, 25329, 23900};
  localparam logic [31:0] NAME_REF [8] = '{"Do  ", "Re  ", "Mi  ", "Fa  ",
                                           "So  ", "La  ", "Si  ", "Do2 "};
  localparam logic [6:0] SEG_REF [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02,
                                          7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21,
                                          7'h06, 7'h0E};

  typedef enum logic [2:0] {ACT_NOTE, ACT_ENABLE, ACT_UP, ACT_DOWN, ACT_CLEAR, ACT_LED} act_t;

  typedef struct packed {
    act_t               act;
    logic [15:0]        arg;
    logic signed [31:0] exp;
  } step_t;

  step_t       steps[$];
  logic        CLK_50M;
  logic        rst;
  logic [2:0]  note_sel;
  logic        sound_en;
  logic        key_up_n;
  logic        key_down_n;
  logic        key_reset_n;
  logic [7:0]  led;
  logic [7:0]  audio_sample;   // Raw byte of the signed sample
  logic [31:0] note_name;
  logic [6:0]  hex0, hex1, hex2, hex3, hex4, hex5;

  organ_top #(
    .LED_TICK_CYCLES (LED_TICK),
    .REPEAT_CYCLES   (REPEAT),
    .REFRESH_CYCLES  (REFRESH)
  ) i_organ_top (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .note_sel     (note_sel),
    .sound_en     (sound_en),
    .key_up_n     (key_up_n),
    .key_down_n   (key_down_n),
    .key_reset_n  (key_reset_n),
    .led          (led),
    .audio_sample (audio_sample),
    .note_name    (note_name),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

  initial begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;   // 50 MHz
  end

  // ==========================================================================
  // Failure reporting and checks
  // ==========================================================================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED at %0t ns: %s, got %0h, expected %0h",
                          $time, msg, actual, expected));
    end
  endtask

  // Bit 4 of the result flags an unknown segment pattern
  function automatic logic [4:0] seg_to_digit(input logic [6:0] seg);
    logic [4:0] res;
    res = 5'h10;
    for (int i = 0; i < 16; i++) begin
      if (SEG_REF[i] == seg) res = {1'b0, 4'(i)};
    end
    return res;
  endfunction

  function automatic logic [31:0] display_value();
    logic [4:0] d [6];
    d[0] = seg_to_digit(hex0);
    d[1] = seg_to_digit(hex1);
    d[2] = seg_to_digit(hex2);
    d[3] = seg_to_digit(hex3);
    d[4] = seg_to_digit(hex4);
    d[5] = seg_to_digit(hex5);
    return {7'b0, d[0][4] | d[1][4] | d[2][4] | d[3][4] | d[4][4] | d[5][4],
            d[5][3:0], d[4][3:0], d[3][3:0], d[2][3:0], d[1][3:0], d[0][3:0]};
  endfunction

  task automatic add_step(input act_t act, input int arg, input int exp);
    step_t s;
    s = '{act: act, arg: 16'(arg), exp: exp};
    steps.push_back(s);
  endtask

  // ==========================================================================
  // Waits, each bounded
  // ==========================================================================
  task automatic wait_sample_change(input int limit, output int cycles);
    logic [7:0] prev;
    bit         seen;
    prev   = audio_sample;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < limit) begin
      @(negedge CLK_50M);
      cycles++;
      if (audio_sample != prev) seen = 1'b1;
    end
    if (!seen) abort_run($sformatf("audio_sample did not change within %0d cycles", limit));
  endtask

  task automatic wait_display(input logic [31:0] expected);
    int n;
    n = 0;
    while (display_value() != expected && n < 2 * REFRESH + 10) begin
      @(negedge CLK_50M);
      n++;
    end
    check(display_value(), expected, "display digits");
  endtask

  task automatic play_note(input logic [2:0] n, input int half);
    int         cycles;
    logic [7:0] prev;
    @(posedge CLK_50M);
    note_sel <= n;
    repeat (3) @(negedge CLK_50M);   // Let the new note settle
    check(note_name, NAME_REF[n], "note name");
    wait_sample_change(half + 10, cycles);   // Align to an edge
    for (int k = 0; k < 2; k++) begin
      prev = audio_sample;
      wait_sample_change(half + 10, cycles);
      check(cycles, half, "half period");
      check(audio_sample, (prev == 8'h7f) ? 8'h80 : 8'h7f, "sample alternation");
    end
  endtask

  task automatic set_enable(input logic en, input int exp);
    @(posedge CLK_50M);
    sound_en <= en;
    repeat (3) @(negedge CLK_50M);
    if (!en) begin
      for (int i = 0; i < DIV_REF[0] + 100; i++) begin   // Longer than any half period
        @(negedge CLK_50M);
        check(audio_sample, exp, "muted sample");
      end
    end
  endtask

  task automatic watch_led(input int count, input int exp);
    logic [7:0] prev;
    logic [7:0] want;
    int         n;
    check($countones(led), exp, "lit LED count");
    for (int k = 0; k < count; k++) begin
      prev = led;
      want = (prev == 8'h80) ? 8'h01 : prev << 1;   // One place up, top wraps to bit 0
      n = 0;
      while (led == prev && n < LED_TICK + 5) begin
        @(negedge CLK_50M);
        n++;
      end
      if (led == prev) abort_run("LED pattern did not move");
      check(led, want, "LED rotation");
      check($countones(led), exp, "lit LED count");
    end
  endtask

  task automatic press_key(input act_t act);
    @(posedge CLK_50M);
    case (act)
      ACT_UP:   key_up_n <= 1'b0;
      ACT_DOWN: key_down_n <= 1'b0;
      default:  key_reset_n <= 1'b0;
    endcase
    repeat (REPEAT) @(posedge CLK_50M);   // Exactly one repeat window
    key_up_n    <= 1'b1;
    key_down_n  <= 1'b1;
    key_reset_n <= 1'b1;
  endtask

  // ==========================================================================
  // Step table and main sequence
  // ==========================================================================
  initial begin
    step_t       s;
    logic [15:0] count;
    rst         = 1'b1;
    note_sel    = 3'd0;
    sound_en    = 1'b0;
    key_up_n    = 1'b1;
    key_down_n  = 1'b1;
    key_reset_n = 1'b1;
    add_step(ACT_ENABLE, 1, 0);
    for (int i = 0; i < 8; i++) add_step(ACT_NOTE, i, DIV_REF[i]);
    add_step(ACT_ENABLE, 0, 32'h80);
    add_step(ACT_LED, 10, 1);
    add_step(ACT_UP, 0, 1);      // Running step count
    add_step(ACT_UP, 0, 2);
    add_step(ACT_DOWN, 0, 1);
    add_step(ACT_DOWN, 0, 0);
    add_step(ACT_DOWN, 0, -1);   // Below the default
    add_step(ACT_DOWN, 0, -2);
    add_step(ACT_UP, 0, -1);
    add_step(ACT_CLEAR, 0, 0);
    add_step(ACT_LED, 4, 1);
    repeat (2) @(posedge CLK_50M);
    rst <= 1'b0;
    @(negedge CLK_50M);
    check(led, 8'h01, "LED after reset");
    check(audio_sample, 8'h80, "sample after reset");
    check(display_value(), 32'h0030D3, "display after reset");
    foreach (steps[i]) begin
      s = steps[i];
      case (s.act)
        ACT_NOTE:   play_note(s.arg[2:0], s.exp);
        ACT_ENABLE: set_enable(s.arg[0], s.exp);
        ACT_LED:    watch_led(s.arg, s.exp);
        default: begin
          press_key(s.act);
          count = 16'(COUNT_BASE + STEP * s.exp);
          wait_display({16'h0000, count});
        end
      endcase
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
organ_pkg.sv
tone_generator.sv
led_chaser.sv
speed_control.sv
hex_display.sv
organ_top.sv
tb_organ_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, then judge the log

rm -f sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_organ_top \
  -Mdir obj_dir -o sim_organ > build.log 2>&1 \
  && ./obj_dir/sim_organ > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null

grep -q "Done: errors found" sim.log && { echo "Simulation FAILED"; exit 1; } \
  || grep -q "Done: no errors" sim.log && echo "Simulation passed" \
  || { echo "Simulation did not complete"; exit 1; }
